//--- Bender.yml
package:
  name: tspp_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/rv32i_core_pkg.sv
      - hw/tspp_fetch_stage.sv
      - hw/rv32i_decoder.sv
      - hw/rv32i_reg_file.sv
      - hw/rv32i_alu.sv
      - hw/tspp_execute_stage.sv
      - hw/dmem_lane_unit.sv
      - hw/tspp_core.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/tspp_core_tb.sv

//--- dv/tspp_core_tb.sv
`timescale 1ns/1ps
`include "rv32i_core_settings.svh"

module tspp_core_tb import rv32i_core_pkg::*; ();

  localparam int    CLK_PERIOD  = 100;
  // worst case cycles per instruction with both buses randomly busy
  localparam int    BUSY_FACTOR = 20;
  localparam int    MAX_CHECKS  = 64;
  localparam word_t STORE_BASE  = 32'h0000_0100;
  localparam word_t VAL_A       = 32'h1234_5678;
  localparam word_t VAL_B       = 32'hFFFF_FFFD;
  localparam word_t VAL_S       = 32'h0000_0025;
  localparam word_t MARKER      = 32'h0000_005A;
  localparam logic [11:0] WRONG_OFF = 12'h0F0;

  logic     CLK = 1'b0;
  logic     nRST = 1'b0;
  logic     imem_ren;
  word_t    imem_addr;
  word_t    imem_rdata;
  logic     imem_busy = 1'b0;
  logic     dmem_ren;
  logic     dmem_wen;
  word_t    dmem_addr;
  byte_en_t dmem_byte_en;
  word_t    dmem_wdata;
  word_t    dmem_rdata;
  logic     dmem_busy = 1'b0;
  logic     halt;
  logic     mal_access;
  word_t    mal_addr;
  logic     store_done;

  word_t       imem [128];
  word_t       dmem [128];
  logic [16:0] lfsr = 17'd89853;
  word_t       asm_pc = '0;
  logic [11:0] st_off = '0;
  int          prog_len = 0;
  // expected stores in program order
  word_t       exp_addr [MAX_CHECKS];
  byte_en_t    exp_be [MAX_CHECKS];
  word_t       exp_wdata [MAX_CHECKS];
  int          st_total = 0;
  int          st_idx = 0;
  word_t       exp_mal [4];
  int          mal_total = 0;
  int          mal_idx = 0;
  int          errors = 0;

  tspp_core tspp_core_i (
    .CLK          (CLK),
    .nRST         (nRST),
    .imem_ren     (imem_ren),
    .imem_addr    (imem_addr),
    .imem_rdata   (imem_rdata),
    .imem_busy    (imem_busy),
    .dmem_ren     (dmem_ren),
    .dmem_wen     (dmem_wen),
    .dmem_addr    (dmem_addr),
    .dmem_byte_en (dmem_byte_en),
    .dmem_wdata   (dmem_wdata),
    .dmem_rdata   (dmem_rdata),
    .dmem_busy    (dmem_busy),
    .halt         (halt),
    .mal_access   (mal_access),
    .mal_addr     (mal_addr)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  // instruction formats
  function automatic word_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                   logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t i_type(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                   reg_idx_t rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t s_type(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                   logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t b_type(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                   logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic word_t u_type(logic [19:0] imm, reg_idx_t rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic word_t j_type(logic [20:0] imm, reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  // every byte of the pattern depends on the word index
  function automatic word_t fill_word(logic [6:0] idx);
    return 32'h8C4E_B2F1 ^ {4{1'b0, idx}};
  endfunction

  // taps x^17 and x^14 with the new bit entering at bit 0
  function automatic logic [16:0] lfsr_next(logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  task automatic log_mismatch(input string name, input word_t got, input word_t want);
    $display("Mismatch %s: got %h, expected %h", name, got, want);
    errors++;
  endtask

  task automatic place_instr(input word_t w);
    imem[asm_pc[8:2]] = w;
    asm_pc = asm_pc + 32'd4;
  endtask

  // store that only a wrong path would execute
  task automatic place_wrong_store();
    place_instr(s_type(WRONG_OFF, 5'd9, 5'd10, 3'b010));
  endtask

  task automatic expect_store(input word_t addr, input byte_en_t be, input word_t data);
    exp_addr[st_total]  = addr;
    exp_be[st_total]    = be;
    exp_wdata[st_total] = data;
    st_total++;
  endtask

  task automatic expect_mal(input word_t addr);
    exp_mal[mal_total] = addr;
    mal_total++;
  endtask

  // instruction writes x3 and a sw sends x3 out
  task automatic check_reg(input word_t instr, input word_t want);
    place_instr(instr);
    place_instr(s_type(st_off, 5'd3, 5'd10, 3'b010));
    expect_store(STORE_BASE + {20'h0, st_off}, 4'hF, want);
    st_off = st_off + 12'd4;
  endtask

  // branch over a marker store so the marker shows up only on fall-through
  task automatic branch_check(input logic [2:0] f3, input reg_idx_t rs1,
                              input reg_idx_t rs2, input bit taken);
    place_instr(b_type(13'd8, rs2, rs1, f3));
    place_instr(s_type(st_off, 5'd5, 5'd10, 3'b010));
    if (!taken)
      expect_store(STORE_BASE + {20'h0, st_off}, 4'hF, MARKER);
    st_off = st_off + 12'd4;
  endtask

  task automatic build_program();
    word_t ld;
    word_t base;
    ld = fill_word(7'd4);
    // x1 and x2 operands, x4 shift amount, x10 store base, x5 and x9 markers
    place_instr(u_type(VAL_A[31:12], 5'd1, OPC_LUI));
    place_instr(i_type(VAL_A[11:0], 5'd1, 3'b000, 5'd1, OPC_OP_IMM));
    place_instr(i_type(VAL_B[11:0], 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
    place_instr(i_type(VAL_S[11:0], 5'd0, 3'b000, 5'd4, OPC_OP_IMM));
    place_instr(i_type(STORE_BASE[11:0], 5'd0, 3'b000, 5'd10, OPC_OP_IMM));
    place_instr(i_type(MARKER[11:0], 5'd0, 3'b000, 5'd5, OPC_OP_IMM));
    place_instr(i_type(12'h07E, 5'd0, 3'b000, 5'd9, OPC_OP_IMM));
    // register and immediate arithmetic
    check_reg(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), VAL_A + VAL_B);
    check_reg(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd3), VAL_A - VAL_B);
    check_reg(r_type(7'h00, 5'd4, 5'd1, 3'b001, 5'd3), VAL_A << VAL_S[4:0]);
    check_reg(r_type(7'h00, 5'd4, 5'd2, 3'b101, 5'd3), VAL_B >> VAL_S[4:0]);
    // -3 keeps its sign bits and ends as -1
    check_reg(r_type(7'h20, 5'd4, 5'd2, 3'b101, 5'd3), 32'hFFFF_FFFF);
    // -3 is below the positive x1 as signed, above it as unsigned
    check_reg(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd3), 32'd1);
    check_reg(r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd3), 32'd0);
    check_reg(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd3), VAL_A ^ VAL_B);
    check_reg(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd3), VAL_A | VAL_B);
    check_reg(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd3), VAL_A & VAL_B);
    check_reg(i_type(12'hFF0, 5'd1, 3'b000, 5'd3, OPC_OP_IMM), VAL_A - 32'd16);
    check_reg(i_type(12'h00C, 5'd1, 3'b001, 5'd3, OPC_OP_IMM), VAL_A << 12);
    check_reg(i_type(12'h008, 5'd1, 3'b101, 5'd3, OPC_OP_IMM), VAL_A >> 8);
    check_reg(i_type(12'h403, 5'd2, 3'b101, 5'd3, OPC_OP_IMM), 32'hFFFF_FFFF);
    check_reg(i_type(12'h000, 5'd2, 3'b010, 5'd3, OPC_OP_IMM), 32'd1);
    check_reg(i_type(12'hFFF, 5'd1, 3'b011, 5'd3, OPC_OP_IMM), 32'd1);
    check_reg(i_type(12'hFFF, 5'd1, 3'b100, 5'd3, OPC_OP_IMM), ~VAL_A);
    check_reg(i_type(12'h0F0, 5'd1, 3'b110, 5'd3, OPC_OP_IMM), VAL_A | 32'h0F0);
    check_reg(i_type(12'h0F0, 5'd1, 3'b111, 5'd3, OPC_OP_IMM), VAL_A & 32'h0F0);
    check_reg(u_type(20'hABCDE, 5'd3, OPC_LUI), 32'hABCD_E000);
    check_reg(u_type(20'h00001, 5'd3, OPC_AUIPC), asm_pc + 32'h0000_1000);
    // sb at every lane and sh at both halves
    for (int k = 0; k < 4; k++) begin
      place_instr(s_type(st_off + 12'(k), 5'd1, 5'd10, 3'b000));
      expect_store(STORE_BASE + {20'h0, st_off} + 32'(k), byte_en_t'(4'b0001 << k),
                   {4{VAL_A[7:0]}});
    end
    st_off = st_off + 12'd4;
    for (int k = 0; k < 2; k++) begin
      place_instr(s_type(st_off + 12'(2 * k), 5'd1, 5'd10, 3'b001));
      expect_store(STORE_BASE + {20'h0, st_off} + 32'(2 * k),
                   (k == 1) ? 4'b1100 : 4'b0011, {2{VAL_A[15:0]}});
    end
    st_off = st_off + 12'd4;
    // loads from the pre-filled word at 0x10
    check_reg(i_type(12'h011, 5'd0, 3'b000, 5'd3, OPC_LOAD), {{24{ld[15]}}, ld[15:8]});
    check_reg(i_type(12'h012, 5'd0, 3'b000, 5'd3, OPC_LOAD), {{24{ld[23]}}, ld[23:16]});
    check_reg(i_type(12'h013, 5'd0, 3'b100, 5'd3, OPC_LOAD), {24'h0, ld[31:24]});
    check_reg(i_type(12'h012, 5'd0, 3'b001, 5'd3, OPC_LOAD), {{16{ld[31]}}, ld[31:16]});
    check_reg(i_type(12'h010, 5'd0, 3'b101, 5'd3, OPC_LOAD), {16'h0, ld[15:0]});
    check_reg(i_type(12'h010, 5'd0, 3'b010, 5'd3, OPC_LOAD), ld);
    // each branch type taken and not taken, x1 positive and x2 negative
    branch_check(BR_BEQ, 5'd1, 5'd1, 1'b1);
    branch_check(BR_BEQ, 5'd1, 5'd2, 1'b0);
    branch_check(BR_BNE, 5'd1, 5'd2, 1'b1);
    branch_check(BR_BNE, 5'd2, 5'd2, 1'b0);
    branch_check(BR_BLT, 5'd2, 5'd1, 1'b1);
    branch_check(BR_BLT, 5'd1, 5'd2, 1'b0);
    branch_check(BR_BGE, 5'd1, 5'd2, 1'b1);
    branch_check(BR_BGE, 5'd2, 5'd1, 1'b0);
    branch_check(BR_BLTU, 5'd1, 5'd2, 1'b1);
    branch_check(BR_BLTU, 5'd2, 5'd1, 1'b0);
    branch_check(BR_BGEU, 5'd2, 5'd1, 1'b1);
    branch_check(BR_BGEU, 5'd1, 5'd2, 1'b0);
    // jal over one store with the link at its pc + 4
    base = asm_pc;
    place_instr(j_type(21'd8, 5'd6));
    place_wrong_store();
    place_instr(s_type(st_off, 5'd6, 5'd10, 3'b010));
    expect_store(STORE_BASE + {20'h0, st_off}, 4'hF, base + 32'd4);
    st_off = st_off + 12'd4;
    // jalr to x7 + 13 with bit 0 cleared lands on base + 12
    base = asm_pc;
    place_instr(u_type(20'h0, 5'd7, OPC_AUIPC));
    place_instr(i_type(12'd13, 5'd7, 3'b000, 5'd8, OPC_JALR));
    place_wrong_store();
    place_instr(s_type(st_off, 5'd8, 5'd10, 3'b010));
    expect_store(STORE_BASE + {20'h0, st_off}, 4'hF, base + 32'd8);
    st_off = st_off + 12'd4;
    // misaligned lw leaves x3 alone and misaligned sh never reaches the bus
    place_instr(i_type(12'h123, 5'd0, 3'b000, 5'd3, OPC_OP_IMM));
    place_instr(i_type(12'h012, 5'd0, 3'b010, 5'd3, OPC_LOAD));
    expect_mal(32'h0000_0012);
    place_instr(s_type(12'h061, 5'd1, 5'd10, 3'b001));
    expect_mal(STORE_BASE + 32'h61);
    place_instr(s_type(st_off, 5'd3, 5'd10, 3'b010));
    expect_store(STORE_BASE + {20'h0, st_off}, 4'hF, 32'h0000_0123);
    place_instr(`RV_HALT_INSTR);
    place_wrong_store();
    place_wrong_store();
    prog_len = asm_pc / 4;
  endtask

  // a busy fetch returns a stray store that must never execute
  assign imem_rdata = imem_busy ? s_type(WRONG_OFF, 5'd9, 5'd10, 3'b010)
                                : imem[imem_addr[8:2]];
  // read data is only good in the completing cycle of a read
  assign dmem_rdata = (dmem_ren && !dmem_busy) ? dmem[dmem_addr[8:2]]
                                               : ~dmem[dmem_addr[8:2]];
  assign store_done = dmem_wen & ~dmem_busy;

  // data memory writes with byte lanes
  always @(posedge CLK) begin
    if (store_done) begin
      for (int k = 0; k < 4; k++) begin
        if (dmem_byte_en[k])
          dmem[dmem_addr[8:2]][8 * k +: 8] <= dmem_wdata[8 * k +: 8];
      end
    end
  end

  // busy is the AND of two lfsr bits on each bus
  always @(posedge CLK) begin
    logic [16:0] s;
    logic [3:0]  bits;
    s = lfsr;
    for (int k = 0; k < 4; k++) begin
      s = lfsr_next(s);
      bits[k] = s[0];
    end
    imem_busy <= bits[0] & bits[1];
    dmem_busy <= bits[2] & bits[3];
    lfsr      <= s;
  end

  // progress line and index step for each store and misaligned access
  always @(posedge CLK) begin
    if (nRST && store_done) begin
      $display("store check %0d seen at %h", st_idx, dmem_addr);
      st_idx <= st_idx + 1;
    end
    if (nRST && mal_access) begin
      $display("misaligned check %0d seen at %h", mal_idx, mal_addr);
      mal_idx <= mal_idx + 1;
    end
  end

  a_store_expected: assert property (@(posedge CLK) disable iff (!nRST)
    store_done |-> (st_idx < st_total))
    else begin
      $display("a store to %h was not expected by the program", $sampled(dmem_addr));
      errors++;
    end

  a_store_addr: assert property (@(posedge CLK) disable iff (!nRST)
    store_done |-> (dmem_addr === exp_addr[st_idx]))
    else log_mismatch("dmem_addr", $sampled(dmem_addr), exp_addr[$sampled(st_idx)]);

  a_store_be: assert property (@(posedge CLK) disable iff (!nRST)
    store_done |-> (dmem_byte_en === exp_be[st_idx]))
    else log_mismatch("dmem_byte_en", 32'($sampled(dmem_byte_en)),
                      32'(exp_be[$sampled(st_idx)]));

  a_store_wdata: assert property (@(posedge CLK) disable iff (!nRST)
    store_done |-> (dmem_wdata === exp_wdata[st_idx]))
    else log_mismatch("dmem_wdata", $sampled(dmem_wdata), exp_wdata[$sampled(st_idx)]);

  a_mal_addr: assert property (@(posedge CLK) disable iff (!nRST)
    mal_access |-> (mal_addr === exp_mal[mal_idx]))
    else log_mismatch("mal_addr", $sampled(mal_addr), exp_mal[$sampled(mal_idx)]);

  a_mal_no_bus: assert property (@(posedge CLK) disable iff (!nRST)
    mal_access |-> (!dmem_ren && !dmem_wen))
    else begin
      $display("a misaligned access still reached the data bus");
      errors++;
    end

  a_halt_sticky: assert property (@(posedge CLK) disable iff (!nRST)
    halt |=> halt)
    else begin
      $display("halt dropped before reset");
      errors++;
    end

  a_halt_idle: assert property (@(posedge CLK) disable iff (!nRST)
    halt |-> (!imem_ren && !dmem_ren && !dmem_wen))
    else begin
      $display("bus activity after halt");
      errors++;
    end

  initial begin
    for (int i = 0; i < 128; i++) begin
      imem[i] = i_type(12'(i), 5'd0, 3'b000, 5'd0, OPC_OP_IMM);
      dmem[i] = fill_word(7'(i));
    end
    build_program();
    repeat (3) @(posedge CLK);
    nRST <= 1'b1;
    while (!halt)
      @(posedge CLK);
    // idle a while so the halt assertions see it stay quiet
    repeat (20) @(posedge CLK);
    if (st_idx != st_total) begin
      $display("only %0d of %0d expected stores were seen", st_idx, st_total);
      errors++;
    end
    if (mal_idx != mal_total) begin
      $display("saw %0d of %0d misaligned accesses", mal_idx, mal_total);
      errors++;
    end
    $display("checks: %0d stores, %0d misaligned accesses, %0d errors",
             st_idx, mal_idx, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // watchdog scaled to the program length
  initial begin
    wait (prog_len > 0);
    #((prog_len * BUSY_FACTOR + 10) * CLK_PERIOD);
    $display("timeout: the core did not reach the halt instruction in time");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- flist.f
+incdir+hw
hw/rv32i_core_pkg.sv
hw/tspp_fetch_stage.sv
hw/rv32i_decoder.sv
hw/rv32i_reg_file.sv
hw/rv32i_alu.sv
hw/tspp_execute_stage.sv
hw/dmem_lane_unit.sv
hw/tspp_core.sv
dv/tspp_core_tb.sv

//--- hw/dmem_lane_unit.sv
`timescale 1ns/1ps

module dmem_lane_unit import rv32i_core_pkg::*; (
  input  logic      mem_ren,
  input  logic      mem_wen,
  input  mem_type_t mem_type,
  input  word_t     mem_addr,
  input  word_t     store_data,
  output word_t     load_data,
  output logic      mem_done,
  output logic      mal,
  output logic      dmem_ren,
  output logic      dmem_wen,
  output word_t     dmem_addr,
  output byte_en_t  dmem_byte_en,
  output word_t     dmem_wdata,
  input  word_t     dmem_rdata,
  input  logic      dmem_busy,
  output logic      mal_access,
  output word_t     mal_addr
);

  logic [1:0] offset;
  word_t      rdata_shifted;

  assign offset = mem_addr[1:0];

  // word needs offset 0, half needs an even offset
  always_comb begin
    case (mem_type)
      MT_W:       mal = (mem_ren | mem_wen) & (offset != 2'b00);
      MT_H, MT_HU: mal = (mem_ren | mem_wen) & offset[0];
      default:    mal = 1'b0;
    endcase
  end

  // bad accesses never reach the bus
  assign dmem_ren  = mem_ren & ~mal;
  assign dmem_wen  = mem_wen & ~mal;
  assign dmem_addr = mem_addr;
  assign mem_done  = (dmem_ren | dmem_wen) & ~dmem_busy;

  // lanes from type and offset, little endian
  always_comb begin
    case (mem_type)
      MT_B, MT_BU: dmem_byte_en = byte_en_t'(4'b0001 << offset);
      MT_H, MT_HU: dmem_byte_en = offset[1] ? 4'b1100 : 4'b0011;
      MT_W:        dmem_byte_en = 4'b1111;
      default:     dmem_byte_en = 4'b0000;
    endcase
  end

  // replicate so every enabled lane carries the value
  always_comb begin
    case (mem_type)
      MT_B, MT_BU: dmem_wdata = {4{store_data[7:0]}};
      MT_H, MT_HU: dmem_wdata = {2{store_data[15:0]}};
      default:     dmem_wdata = store_data;
    endcase
  end

  // bring the addressed lane down to bit 0, then extend
  assign rdata_shifted = dmem_rdata >> {offset, 3'b000};

  always_comb begin
    case (mem_type)
      MT_B:    load_data = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
      MT_BU:   load_data = {24'b0, rdata_shifted[7:0]};
      MT_H:    load_data = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
      MT_HU:   load_data = {16'b0, rdata_shifted[15:0]};
      default: load_data = dmem_rdata;
    endcase
  end

  // single cycle flag, the instruction retires in that cycle
  assign mal_access = mal;
  assign mal_addr   = mal ? mem_addr : '0;

  a_one_direction: assert final (!(dmem_ren && dmem_wen));

endmodule

//--- hw/rv32i_alu.sv
`timescale 1ns/1ps

module rv32i_alu import rv32i_core_pkg::*; (
  input  alu_op_t alu_op,
  input  word_t   port_a,
  input  word_t   port_b,
  output word_t   port_out
);

  logic [4:0] shamt;

  // shifts only look at the low five bits
  assign shamt = port_b[4:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:  port_out = port_a + port_b;
      ALU_SUB:  port_out = port_a - port_b;
      ALU_SLL:  port_out = port_a << shamt;
      ALU_SLT:  port_out = {31'b0, $signed(port_a) < $signed(port_b)};
      ALU_SLTU: port_out = {31'b0, port_a < port_b};
      ALU_XOR:  port_out = port_a ^ port_b;
      ALU_SRL:  port_out = port_a >> shamt;
      // arithmetic shift keeps the sign bit
      ALU_SRA:  port_out = word_t'($signed(port_a) >>> shamt);
      ALU_OR:   port_out = port_a | port_b;
      ALU_AND:  port_out = port_a & port_b;
      default:  port_out = '0;
    endcase
  end

endmodule

//--- hw/rv32i_core_pkg.sv
package rv32i_core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  // bit 0 is the lane at address offset 0
  typedef logic [3:0]  byte_en_t;
  typedef logic [3:0]  alu_op_t;
  // same encoding as funct3 of loads and stores
  typedef logic [2:0]  mem_type_t;
  typedef logic [1:0]  wb_sel_t;

  // alu codes are {funct7[5], funct3} so OP decodes without a table
  localparam alu_op_t ALU_ADD  = 4'b0000;
  localparam alu_op_t ALU_SUB  = 4'b1000;
  localparam alu_op_t ALU_SLL  = 4'b0001;
  localparam alu_op_t ALU_SLT  = 4'b0010;
  localparam alu_op_t ALU_SLTU = 4'b0011;
  localparam alu_op_t ALU_XOR  = 4'b0100;
  localparam alu_op_t ALU_SRL  = 4'b0101;
  localparam alu_op_t ALU_SRA  = 4'b1101;
  localparam alu_op_t ALU_OR   = 4'b0110;
  localparam alu_op_t ALU_AND  = 4'b0111;

  localparam mem_type_t MT_B  = 3'b000;
  localparam mem_type_t MT_H  = 3'b001;
  localparam mem_type_t MT_W  = 3'b010;
  localparam mem_type_t MT_BU = 3'b100;
  localparam mem_type_t MT_HU = 3'b101;

  localparam wb_sel_t WB_ALU  = 2'd0;
  localparam wb_sel_t WB_LOAD = 2'd1;
  localparam wb_sel_t WB_PC4  = 2'd2;
  localparam wb_sel_t WB_IMMU = 2'd3;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  localparam logic [2:0] BR_BEQ  = 3'b000;
  localparam logic [2:0] BR_BNE  = 3'b001;
  localparam logic [2:0] BR_BLT  = 3'b100;
  localparam logic [2:0] BR_BGE  = 3'b101;
  localparam logic [2:0] BR_BLTU = 3'b110;
  localparam logic [2:0] BR_BGEU = 3'b111;

endpackage

//--- hw/rv32i_core_settings.svh
`ifndef RV32I_CORE_SETTINGS_SVH
`define RV32I_CORE_SETTINGS_SVH

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// all ones has opcode 7'h7f, which no RV32I instruction uses
`define RV_HALT_INSTR 32'hFFFF_FFFF

// architectural integer registers including x0
`define RV_NUM_REGS 32

`endif

//--- hw/rv32i_decoder.sv
`timescale 1ns/1ps
`include "rv32i_core_settings.svh"

module rv32i_decoder import rv32i_core_pkg::*; (
  input  word_t     instr,
  output alu_op_t   alu_op,
  output logic      a_sel_pc,
  output logic      b_sel_imm,
  output word_t     imm,
  output reg_idx_t  rs1,
  output reg_idx_t  rs2,
  output reg_idx_t  rd,
  output logic      reg_wen,
  output logic      mem_ren,
  output logic      mem_wen,
  output logic      branch,
  output logic      jal,
  output logic      jalr,
  output logic      halt_instr,
  output mem_type_t mem_type,
  output wb_sel_t   wb_sel
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign rs1      = instr[19:15];
  assign rs2      = instr[24:20];
  assign rd       = instr[11:7];
  assign mem_type = funct3;

  assign halt_instr = (instr == `RV_HALT_INSTR);

  // sign-extended immediates, one per format
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    // anything not listed falls through as a no-op
    alu_op    = ALU_ADD;
    a_sel_pc  = 1'b0;
    b_sel_imm = 1'b0;
    imm       = imm_i;
    reg_wen   = 1'b0;
    mem_ren   = 1'b0;
    mem_wen   = 1'b0;
    branch    = 1'b0;
    jal       = 1'b0;
    jalr      = 1'b0;
    wb_sel    = WB_ALU;
    case (opcode)
      OPC_LUI: begin
        imm     = imm_u;
        reg_wen = 1'b1;
        wb_sel  = WB_IMMU;
      end
      OPC_AUIPC: begin
        imm       = imm_u;
        a_sel_pc  = 1'b1;
        b_sel_imm = 1'b1;
        reg_wen   = 1'b1;
      end
      OPC_JAL: begin
        imm     = imm_j;
        jal     = 1'b1;
        reg_wen = 1'b1;
        wb_sel  = WB_PC4;
      end
      OPC_JALR: begin
        jalr    = 1'b1;
        reg_wen = 1'b1;
        wb_sel  = WB_PC4;
      end
      OPC_BRANCH: begin
        imm    = imm_b;
        branch = 1'b1;
      end
      OPC_LOAD: begin
        b_sel_imm = 1'b1;
        mem_ren   = 1'b1;
        reg_wen   = 1'b1;
        wb_sel    = WB_LOAD;
      end
      OPC_STORE: begin
        imm       = imm_s;
        b_sel_imm = 1'b1;
        mem_wen   = 1'b1;
      end
      OPC_OP_IMM: begin
        b_sel_imm = 1'b1;
        reg_wen   = 1'b1;
        // bit 30 only selects srai, elsewhere it is immediate data
        alu_op    = {(funct3 == ALU_SRL[2:0]) & instr[30], funct3};
      end
      OPC_OP: begin
        reg_wen = 1'b1;
        alu_op  = {instr[30], funct3};
      end
      default: begin
        reg_wen = 1'b0;
      end
    endcase
  end

endmodule

//--- hw/rv32i_reg_file.sv
`timescale 1ns/1ps
`include "rv32i_core_settings.svh"

module rv32i_reg_file import rv32i_core_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rs1_data,
  output word_t    rs2_data,
  input  logic     wen,
  input  reg_idx_t rd,
  input  word_t    w_data
);

  word_t regs [`RV_NUM_REGS];

  // write at the edge, visible to reads the cycle after
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < `RV_NUM_REGS; i++)
        regs[i] <= '0;
    end else if (wen && (rd != '0)) begin
      // x0 never takes a write so it reads zero
      regs[rd] <= w_data;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

//--- hw/tspp_core.sv
`timescale 1ns/1ps

module tspp_core import rv32i_core_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  output logic     imem_ren,
  output word_t    imem_addr,
  input  word_t    imem_rdata,
  input  logic     imem_busy,
  output logic     dmem_ren,
  output logic     dmem_wen,
  output word_t    dmem_addr,
  output byte_en_t dmem_byte_en,
  output word_t    dmem_wdata,
  input  word_t    dmem_rdata,
  input  logic     dmem_busy,
  output logic     halt,
  output logic     mal_access,
  output word_t    mal_addr
);

  // fetch to execute
  logic      fe_valid;
  word_t     fe_instr;
  word_t     fe_pc;
  word_t     fe_pc4;
  // execute back to fetch
  logic      ex_stall;
  logic      redirect;
  word_t     redirect_addr;
  // execute to and from the lane unit
  logic      mem_ren;
  logic      mem_wen;
  mem_type_t mem_type;
  word_t     mem_addr;
  word_t     store_data;
  word_t     load_data;
  logic      mem_done;
  logic      mal;

  tspp_fetch_stage fetch_i (
    .CLK           (CLK),
    .nRST          (nRST),
    .halt          (halt),
    .ex_stall      (ex_stall),
    .redirect      (redirect),
    .redirect_addr (redirect_addr),
    .imem_ren      (imem_ren),
    .imem_addr     (imem_addr),
    .imem_rdata    (imem_rdata),
    .imem_busy     (imem_busy),
    .fe_valid      (fe_valid),
    .fe_instr      (fe_instr),
    .fe_pc         (fe_pc),
    .fe_pc4        (fe_pc4)
  );

  tspp_execute_stage execute_i (
    .CLK           (CLK),
    .nRST          (nRST),
    .fe_valid      (fe_valid),
    .fe_instr      (fe_instr),
    .fe_pc         (fe_pc),
    .fe_pc4        (fe_pc4),
    .ex_stall      (ex_stall),
    .redirect      (redirect),
    .redirect_addr (redirect_addr),
    .mem_ren       (mem_ren),
    .mem_wen       (mem_wen),
    .mem_type      (mem_type),
    .mem_addr      (mem_addr),
    .store_data    (store_data),
    .load_data     (load_data),
    .mem_done      (mem_done),
    .mal           (mal),
    .halt          (halt)
  );

  dmem_lane_unit lane_i (
    .mem_ren      (mem_ren),
    .mem_wen      (mem_wen),
    .mem_type     (mem_type),
    .mem_addr     (mem_addr),
    .store_data   (store_data),
    .load_data    (load_data),
    .mem_done     (mem_done),
    .mal          (mal),
    .dmem_ren     (dmem_ren),
    .dmem_wen     (dmem_wen),
    .dmem_addr    (dmem_addr),
    .dmem_byte_en (dmem_byte_en),
    .dmem_wdata   (dmem_wdata),
    .dmem_rdata   (dmem_rdata),
    .dmem_busy    (dmem_busy),
    .mal_access   (mal_access),
    .mal_addr     (mal_addr)
  );

endmodule

//--- hw/tspp_execute_stage.sv
`timescale 1ns/1ps

module tspp_execute_stage import rv32i_core_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  logic      fe_valid,
  input  word_t     fe_instr,
  input  word_t     fe_pc,
  input  word_t     fe_pc4,
  output logic      ex_stall,
  output logic      redirect,
  output word_t     redirect_addr,
  output logic      mem_ren,
  output logic      mem_wen,
  output mem_type_t mem_type,
  output word_t     mem_addr,
  output word_t     store_data,
  input  word_t     load_data,
  input  logic      mem_done,
  input  logic      mal,
  output logic      halt
);

  alu_op_t  alu_op;
  logic     a_sel_pc;
  logic     b_sel_imm;
  word_t    imm;
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  logic     dec_reg_wen;
  logic     dec_mem_ren;
  logic     dec_mem_wen;
  logic     branch;
  logic     jal;
  logic     jalr;
  logic     halt_instr;
  wb_sel_t  wb_sel;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    port_a;
  word_t    port_b;
  word_t    alu_out;
  word_t    w_data;
  logic     rf_wen;
  logic     valid;
  logic     br_taken;
  word_t    pc_target;
  word_t    jalr_sum;

  rv32i_decoder decoder_i (
    .instr      (fe_instr),
    .alu_op     (alu_op),
    .a_sel_pc   (a_sel_pc),
    .b_sel_imm  (b_sel_imm),
    .imm        (imm),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .reg_wen    (dec_reg_wen),
    .mem_ren    (dec_mem_ren),
    .mem_wen    (dec_mem_wen),
    .branch     (branch),
    .jal        (jal),
    .jalr       (jalr),
    .halt_instr (halt_instr),
    .mem_type   (mem_type),
    .wb_sel     (wb_sel)
  );

  rv32i_reg_file reg_file_i (
    .CLK      (CLK),
    .nRST     (nRST),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wen      (rf_wen),
    .rd       (rd),
    .w_data   (w_data)
  );

  rv32i_alu alu_i (
    .alu_op   (alu_op),
    .port_a   (port_a),
    .port_b   (port_b),
    .port_out (alu_out)
  );

  // the word that was in flight when halt rose must not run
  assign valid = fe_valid & ~halt;

  assign port_a = a_sel_pc ? fe_pc : rs1_data;
  assign port_b = b_sel_imm ? imm : rs2_data;

  // branch compare straight off the register file
  always_comb begin
    case (fe_instr[14:12])
      BR_BEQ:  br_taken = (rs1_data == rs2_data);
      BR_BNE:  br_taken = (rs1_data != rs2_data);
      BR_BLT:  br_taken = ($signed(rs1_data) < $signed(rs2_data));
      BR_BGE:  br_taken = ($signed(rs1_data) >= $signed(rs2_data));
      BR_BLTU: br_taken = (rs1_data < rs2_data);
      BR_BGEU: br_taken = (rs1_data >= rs2_data);
      default: br_taken = 1'b0;
    endcase
  end

  // jal and branches share the pc-relative adder
  assign pc_target     = fe_pc + imm;
  assign jalr_sum      = rs1_data + imm;
  assign redirect      = valid & (jal | jalr | (branch & br_taken));
  assign redirect_addr = jalr ? {jalr_sum[31:1], 1'b0} : pc_target;

  // data side, address always comes from the alu add
  assign mem_ren    = valid & dec_mem_ren;
  assign mem_wen    = valid & dec_mem_wen;
  assign mem_addr   = alu_out;
  assign store_data = rs2_data;

  // hold fetch until the bus finishes, a misaligned access retires at once
  assign ex_stall = (mem_ren | mem_wen) & ~mem_done & ~mal;

  always_comb begin
    case (wb_sel)
      WB_LOAD: w_data = load_data;
      WB_PC4:  w_data = fe_pc4;
      WB_IMMU: w_data = imm;
      default: w_data = alu_out;
    endcase
  end

  // load writes only on its completing cycle
  assign rf_wen = valid & dec_reg_wen & ~(mem_ren & ~mem_done) & ~mal;

  // sticky until reset
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST)
      halt <= 1'b0;
    else if (valid && halt_instr)
      halt <= 1'b1;
  end

  // a memory op never redirects, so fetch sees one request at a time
  a_no_redirect_in_stall: assert property (@(posedge CLK) disable iff (!nRST)
    !(redirect && ex_stall));

endmodule

//--- hw/tspp_fetch_stage.sv
`timescale 1ns/1ps
`include "rv32i_core_settings.svh"

module tspp_fetch_stage import rv32i_core_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  halt,
  input  logic  ex_stall,
  input  logic  redirect,
  input  word_t redirect_addr,
  output logic  imem_ren,
  output word_t imem_addr,
  input  word_t imem_rdata,
  input  logic  imem_busy,
  output logic  fe_valid,
  output word_t fe_instr,
  output word_t fe_pc,
  output word_t fe_pc4
);

  word_t pc;
  word_t pc4;
  logic  fetch_done;

  // fetching stops for good once the core halts
  assign imem_ren   = ~halt;
  assign imem_addr  = pc;
  assign pc4        = pc + 32'd4;
  assign fetch_done = imem_ren & ~imem_busy;

  // control state, pc and valid bit
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc       <= `RV_RESET_PC;
      fe_valid <= 1'b0;
    end else if (halt) begin
      fe_valid <= 1'b0;
    end else if (redirect) begin
      // not-taken guess was wrong, drop the fall-through word
      pc       <= redirect_addr;
      fe_valid <= 1'b0;
    end else if (!ex_stall) begin
      // busy cycle leaves a bubble behind
      fe_valid <= fetch_done;
      if (fetch_done)
        pc <= pc4;
    end
  end

  // payload only moves with a completed fetch
  always_ff @(posedge CLK) begin
    if (!halt && !redirect && !ex_stall && fetch_done) begin
      fe_instr <= imem_rdata;
      fe_pc    <= pc;
      fe_pc4   <= pc4;
    end
  end

  // jump targets reaching the bus must be word aligned
  a_imem_aligned: assert property (@(posedge CLK) disable iff (!nRST)
    imem_ren |-> (imem_addr[1:0] == 2'b00));

endmodule
